// ==== src/rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    // ******************************************************************
    // widths, fixed by the base isa
    // ******************************************************************
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // architectural register number, x0 hardwired to zero
    typedef logic [REG_ADDR_W-1:0] rv32i_reg;
    // one data word
    typedef logic [XLEN-1:0] rv32i_word;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    // branch condition, funct3 of a B-type instruction
    // 010 and 011 are not defined by the isa
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    // ******************************************************************
    // forwarding mux selects
    // ******************************************************************

    // source of an EX-stage alu operand
    typedef enum logic [2:0] {
        id_ex        = 3'd0,
        ex_mem       = 3'd1,
        u_imm_ex_mem = 3'd2,
        mem_wb       = 3'd3,
        u_imm_mem_wb = 3'd4,
        mem_wb_ld    = 3'd5
    } fwd_ex_sel_t;

    // source of the MEM-stage store data
    typedef enum logic {
        mem = 1'b0,
        wb  = 1'b1
    } fwd_st_sel_t;

    // source of a decode-stage branch comparison operand
    typedef enum logic [2:0] {
        id      = 3'd0,
        ex      = 3'd1,
        mem_alu = 3'd2,
        mem_ld  = 3'd3,
        wb_alu  = 3'd4,
        wb_ld   = 3'd5
    } fwd_br_sel_t;

endpackage : rv32i_pkg

`default_nettype wire

// ==== src/ex_forward_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_forward_unit (
    // EX source registers
    input  rv32i_pkg::rv32i_reg      ex_rs1_i,
    input  rv32i_pkg::rv32i_reg      ex_rs2_i,
    // producers in MEM and WB
    input  rv32i_pkg::rv32i_reg      mem_rd_i,
    input  rv32i_pkg::rv32i_reg      mem_rs2_i,
    input  rv32i_pkg::rv32i_reg      wb_rd_i,
    input  logic                     mem_load_regfile_i,
    input  logic                     wb_load_regfile_i,
    input  rv32i_pkg::rv32i_opcode_t mem_opcode_i,
    input  rv32i_pkg::rv32i_opcode_t wb_opcode_i,
    // mux selects
    output rv32i_pkg::fwd_ex_sel_t   fwd_a_sel_o,
    output rv32i_pkg::fwd_ex_sel_t   fwd_b_sel_o,
    output rv32i_pkg::fwd_st_sel_t   fwd_st_sel_o
);
    import rv32i_pkg::*;

    // per-operand hazard flags
    logic mem_haz_a;
    logic wb_haz_a;
    logic mem_haz_b;
    logic wb_haz_b;
    // load in WB feeding a store in MEM
    logic ld_st_haz;

    // producer writes a nonzero rd that the consumer reads
    function automatic logic raw_hit(input logic we, input rv32i_reg rd, input rv32i_reg rs);
        raw_hit = we & (|rd) & (rd == rs);
    endfunction

    // newer stage wins, then refine by what the producer computes
    function automatic fwd_ex_sel_t pick_src(input logic          mem_hit,
                                             input logic          wb_hit,
                                             input rv32i_opcode_t mem_op,
                                             input rv32i_opcode_t wb_op);
        if (mem_hit) begin
            // lui result sits in the u immediate, not the alu bus
            if (mem_op == op_lui) pick_src = u_imm_ex_mem;
            else                  pick_src = ex_mem;
        end else if (wb_hit) begin
            if (wb_op == op_load)     pick_src = mem_wb_ld;
            else if (wb_op == op_lui) pick_src = u_imm_mem_wb;
            else                      pick_src = mem_wb;
        end else begin
            pick_src = id_ex;
        end
    endfunction

    // ******************************************************************
    // EX operand hazards
    // ******************************************************************
    always_comb begin
        mem_haz_a = raw_hit(mem_load_regfile_i, mem_rd_i, ex_rs1_i);
        wb_haz_a  = raw_hit(wb_load_regfile_i, wb_rd_i, ex_rs1_i);
        mem_haz_b = raw_hit(mem_load_regfile_i, mem_rd_i, ex_rs2_i);
        wb_haz_b  = raw_hit(wb_load_regfile_i, wb_rd_i, ex_rs2_i);

        fwd_a_sel_o = pick_src(mem_haz_a, wb_haz_a, mem_opcode_i, wb_opcode_i);
        fwd_b_sel_o = pick_src(mem_haz_b, wb_haz_b, mem_opcode_i, wb_opcode_i);
    end

    // ******************************************************************
    // store data, WB -> MEM
    // ******************************************************************
    always_comb begin
        // load value only exists in WB, store needs it now
        ld_st_haz = (mem_opcode_i == op_store)
                  & (wb_opcode_i == op_load)
                  & (|wb_rd_i)
                  & (wb_rd_i == mem_rs2_i);

        if (ld_st_haz) fwd_st_sel_o = wb;
        else           fwd_st_sel_o = mem;
    end

endmodule : ex_forward_unit

`default_nettype wire

// ==== src/branch_forward_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module branch_forward_unit (
    // decode-stage branch sources
    input  rv32i_pkg::rv32i_reg      id_rs1_i,
    input  rv32i_pkg::rv32i_reg      id_rs2_i,
    // producers further down the pipe
    input  rv32i_pkg::rv32i_reg      ex_rd_i,
    input  rv32i_pkg::rv32i_reg      mem_rd_i,
    input  rv32i_pkg::rv32i_reg      wb_rd_i,
    input  logic                     ex_load_regfile_i,
    input  logic                     mem_load_regfile_i,
    input  logic                     wb_load_regfile_i,
    input  rv32i_pkg::rv32i_opcode_t mem_opcode_i,
    input  rv32i_pkg::rv32i_opcode_t wb_opcode_i,
    // selects for comparator inputs
    output rv32i_pkg::fwd_br_sel_t   fwd_d_sel_o,
    output rv32i_pkg::fwd_br_sel_t   fwd_e_sel_o
);
    import rv32i_pkg::*;

    // hit flags, rs1 side (d) and rs2 side (e)
    logic ex_haz_d;
    logic mem_haz_d;
    logic wb_haz_d;
    logic ex_haz_e;
    logic mem_haz_e;
    logic wb_haz_e;

    function automatic logic raw_hit(input logic we, input rv32i_reg rd, input rv32i_reg rs);
        raw_hit = we & (|rd) & (rd == rs);
    endfunction

    // EX beats MEM beats WB
    // load data and alu results come back on separate buses
    function automatic fwd_br_sel_t pick_src(input logic          ex_hit,
                                             input logic          mem_hit,
                                             input logic          wb_hit,
                                             input rv32i_opcode_t mem_op,
                                             input rv32i_opcode_t wb_op);
        if (ex_hit) begin
            pick_src = ex;
        end else if (mem_hit) begin
            if (mem_op == op_load) pick_src = mem_ld;
            else                   pick_src = mem_alu;
        end else if (wb_hit) begin
            if (wb_op == op_load) pick_src = wb_ld;
            else                  pick_src = wb_alu;
        end else begin
            pick_src = id;
        end
    endfunction

    // ******************************************************************
    // branch operand hazards
    // ******************************************************************
    always_comb begin
        ex_haz_d  = raw_hit(ex_load_regfile_i, ex_rd_i, id_rs1_i);
        mem_haz_d = raw_hit(mem_load_regfile_i, mem_rd_i, id_rs1_i);
        wb_haz_d  = raw_hit(wb_load_regfile_i, wb_rd_i, id_rs1_i);

        ex_haz_e  = raw_hit(ex_load_regfile_i, ex_rd_i, id_rs2_i);
        mem_haz_e = raw_hit(mem_load_regfile_i, mem_rd_i, id_rs2_i);
        wb_haz_e  = raw_hit(wb_load_regfile_i, wb_rd_i, id_rs2_i);

        fwd_d_sel_o = pick_src(ex_haz_d, mem_haz_d, wb_haz_d, mem_opcode_i, wb_opcode_i);
        fwd_e_sel_o = pick_src(ex_haz_e, mem_haz_e, wb_haz_e, mem_opcode_i, wb_opcode_i);
    end

endmodule : branch_forward_unit

`default_nettype wire

// ==== src/operand_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_router (
    input  logic                      clk,
    input  logic                      rst_n_i,
    // selects from the two forwarding units
    input  rv32i_pkg::fwd_ex_sel_t    fwd_a_sel_i,
    input  rv32i_pkg::fwd_ex_sel_t    fwd_b_sel_i,
    input  rv32i_pkg::fwd_st_sel_t    fwd_st_sel_i,
    input  rv32i_pkg::fwd_br_sel_t    fwd_d_sel_i,
    input  rv32i_pkg::fwd_br_sel_t    fwd_e_sel_i,
    input  rv32i_pkg::branch_funct3_t br_funct3_i,
    // stage values
    input  rv32i_pkg::rv32i_word      id_rs1_val_i,
    input  rv32i_pkg::rv32i_word      id_rs2_val_i,
    input  rv32i_pkg::rv32i_word      ex_rs1_val_i,
    input  rv32i_pkg::rv32i_word      ex_rs2_val_i,
    input  rv32i_pkg::rv32i_word      ex_alu_i,
    input  rv32i_pkg::rv32i_word      mem_alu_i,
    input  rv32i_pkg::rv32i_word      mem_u_imm_i,
    input  rv32i_pkg::rv32i_word      mem_rdata_i,
    input  rv32i_pkg::rv32i_word      mem_rs2_val_i,
    input  rv32i_pkg::rv32i_word      wb_alu_i,
    input  rv32i_pkg::rv32i_word      wb_u_imm_i,
    input  rv32i_pkg::rv32i_word      wb_rdata_i,
    // registered results
    output rv32i_pkg::rv32i_word      ex_opnd_a_o,
    output rv32i_pkg::rv32i_word      ex_opnd_b_o,
    output rv32i_pkg::rv32i_word      mem_wdata_o,
    output logic                      br_taken_o
);
    import rv32i_pkg::*;

    rv32i_word opnd_a;
    rv32i_word opnd_b;
    rv32i_word st_data;
    rv32i_word br_lhs;
    rv32i_word br_rhs;
    logic      br_cond;

    // ALU operand mux, own value is the ID/EX register copy
    function automatic rv32i_word ex_mux(input fwd_ex_sel_t sel, input rv32i_word own_val);
        case (sel)
            ex_mem:       ex_mux = mem_alu_i;
            u_imm_ex_mem: ex_mux = mem_u_imm_i;
            mem_wb:       ex_mux = wb_alu_i;
            u_imm_mem_wb: ex_mux = wb_u_imm_i;
            mem_wb_ld:    ex_mux = wb_rdata_i;
            default:      ex_mux = own_val;
        endcase
    endfunction

    // comparator mux, own value is the regfile read
    function automatic rv32i_word br_mux(input fwd_br_sel_t sel, input rv32i_word own_val);
        case (sel)
            ex:      br_mux = ex_alu_i;
            mem_alu: br_mux = mem_alu_i;
            mem_ld:  br_mux = mem_rdata_i;
            wb_alu:  br_mux = wb_alu_i;
            wb_ld:   br_mux = wb_rdata_i;
            default: br_mux = own_val;
        endcase
    endfunction

    // ******************************************************************
    // operand muxes and branch compare
    // ******************************************************************
    always_comb begin
        opnd_a  = ex_mux(fwd_a_sel_i, ex_rs1_val_i);
        opnd_b  = ex_mux(fwd_b_sel_i, ex_rs2_val_i);
        st_data = (fwd_st_sel_i == wb) ? wb_rdata_i : mem_rs2_val_i;
        br_lhs  = br_mux(fwd_d_sel_i, id_rs1_val_i);
        br_rhs  = br_mux(fwd_e_sel_i, id_rs2_val_i);

        case (br_funct3_i)
            beq:     br_cond = (br_lhs == br_rhs);
            bne:     br_cond = (br_lhs != br_rhs);
            blt:     br_cond = ($signed(br_lhs) < $signed(br_rhs));
            bge:     br_cond = ($signed(br_lhs) >= $signed(br_rhs));
            bltu:    br_cond = (br_lhs < br_rhs);
            bgeu:    br_cond = (br_lhs >= br_rhs);
            // reserved funct3, never taken
            default: br_cond = 1'b0;
        endcase
    end

    // one cycle of latency, all results move together
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_opnd_a_o <= '0;
            ex_opnd_b_o <= '0;
            mem_wdata_o <= '0;
            br_taken_o  <= 1'b0;
        end else begin
            ex_opnd_a_o <= opnd_a;
            ex_opnd_b_o <= opnd_b;
            mem_wdata_o <= st_data;
            br_taken_o  <= br_cond;
        end
    end

endmodule : operand_router

`default_nettype wire

// ==== src/forward_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module forward_top (
    input  logic                      clk,
    input  logic                      rst_n_i,
    // register numbers per stage
    input  rv32i_pkg::rv32i_reg       id_rs1_i,
    input  rv32i_pkg::rv32i_reg       id_rs2_i,
    input  rv32i_pkg::rv32i_reg       ex_rd_i,
    input  rv32i_pkg::rv32i_reg       ex_rs1_i,
    input  rv32i_pkg::rv32i_reg       ex_rs2_i,
    input  rv32i_pkg::rv32i_reg       mem_rd_i,
    input  rv32i_pkg::rv32i_reg       mem_rs2_i,
    input  rv32i_pkg::rv32i_reg       wb_rd_i,
    // regfile write enables
    input  logic                      ex_load_regfile_i,
    input  logic                      mem_load_regfile_i,
    input  logic                      wb_load_regfile_i,
    input  rv32i_pkg::rv32i_opcode_t  mem_opcode_i,
    input  rv32i_pkg::rv32i_opcode_t  wb_opcode_i,
    input  rv32i_pkg::branch_funct3_t br_funct3_i,
    // values held in the pipeline registers
    input  rv32i_pkg::rv32i_word      id_rs1_val_i,
    input  rv32i_pkg::rv32i_word      id_rs2_val_i,
    input  rv32i_pkg::rv32i_word      ex_rs1_val_i,
    input  rv32i_pkg::rv32i_word      ex_rs2_val_i,
    input  rv32i_pkg::rv32i_word      ex_alu_i,
    input  rv32i_pkg::rv32i_word      mem_alu_i,
    input  rv32i_pkg::rv32i_word      mem_u_imm_i,
    input  rv32i_pkg::rv32i_word      mem_rdata_i,
    input  rv32i_pkg::rv32i_word      mem_rs2_val_i,
    input  rv32i_pkg::rv32i_word      wb_alu_i,
    input  rv32i_pkg::rv32i_word      wb_u_imm_i,
    input  rv32i_pkg::rv32i_word      wb_rdata_i,
    // registered results
    output rv32i_pkg::rv32i_word      ex_opnd_a_o,
    output rv32i_pkg::rv32i_word      ex_opnd_b_o,
    output rv32i_pkg::rv32i_word      mem_wdata_o,
    output logic                      br_taken_o
);
    import rv32i_pkg::*;

    // selects between the hazard units and the router
    fwd_ex_sel_t fwd_a_sel;
    fwd_ex_sel_t fwd_b_sel;
    fwd_st_sel_t fwd_st_sel;
    fwd_br_sel_t fwd_d_sel;
    fwd_br_sel_t fwd_e_sel;

    // ******************************************************************
    // hazard detection, both combinational
    // ******************************************************************
    ex_forward_unit u_ex_fwd (
        .fwd_a_sel_o  (fwd_a_sel),
        .fwd_b_sel_o  (fwd_b_sel),
        .fwd_st_sel_o (fwd_st_sel),
        .*
    );

    branch_forward_unit u_br_fwd (
        .fwd_d_sel_o (fwd_d_sel),
        .fwd_e_sel_o (fwd_e_sel),
        .*
    );

    // value muxes, compare, output flops
    operand_router u_router (
        .fwd_a_sel_i  (fwd_a_sel),
        .fwd_b_sel_i  (fwd_b_sel),
        .fwd_st_sel_i (fwd_st_sel),
        .fwd_d_sel_i  (fwd_d_sel),
        .fwd_e_sel_i  (fwd_e_sel),
        .*
    );

endmodule : forward_top

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    // 40 ns period
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // reset held for 16 cycles, released on a falling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== bench/forward_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module forward_tb;
    import rv32i_pkg::*;

    // about 76 cycles of work in total, 20 per test leaves margin
    localparam int N_TESTS         = 6;
    localparam int WATCHDOG_CYCLES = N_TESTS * 20;
    localparam int STREAM_LEN      = 24;

    logic clk;
    logic rst_n_i;

    // stage contents, named after the dut ports
    rv32i_reg       id_rs1_i, id_rs2_i, ex_rd_i, ex_rs1_i, ex_rs2_i;
    rv32i_reg       mem_rd_i, mem_rs2_i, wb_rd_i;
    logic           ex_load_regfile_i, mem_load_regfile_i, wb_load_regfile_i;
    rv32i_opcode_t  mem_opcode_i, wb_opcode_i;
    branch_funct3_t br_funct3_i;
    rv32i_word      id_rs1_val_i, id_rs2_val_i, ex_rs1_val_i, ex_rs2_val_i, ex_alu_i;
    rv32i_word      mem_alu_i, mem_u_imm_i, mem_rdata_i, mem_rs2_val_i;
    rv32i_word      wb_alu_i, wb_u_imm_i, wb_rdata_i;
    // registered results
    rv32i_word      ex_opnd_a_o, ex_opnd_b_o, mem_wdata_o;
    logic           br_taken_o;

    int test_errs;
    int tests_passed;
    int tests_failed;

    rv32i_opcode_t  op_tbl[9]   = '{op_lui, op_auipc, op_jal, op_jalr, op_br,
                                    op_load, op_store, op_imm, op_reg};
    branch_funct3_t cond_tbl[6] = '{beq, bne, blt, bge, bltu, bgeu};

    tb_clock_gen u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n_i)
    );

    forward_top dut (.*);

    // ******************************************************************
    // reference rules
    // ******************************************************************

    // producer writes a nonzero rd equal to the source
    function automatic logic writes_reg(input logic we, input rv32i_reg rd, input rv32i_reg rs);
        return we && (rd != 5'd0) && (rd == rs);
    endfunction

    // MEM is newer than WB, so it is asked first
    function automatic rv32i_word expected_ex_operand(input rv32i_reg rs, input rv32i_word own);
        if (writes_reg(mem_load_regfile_i, mem_rd_i, rs)) begin
            return (mem_opcode_i == op_lui) ? mem_u_imm_i : mem_alu_i;
        end
        if (writes_reg(wb_load_regfile_i, wb_rd_i, rs)) begin
            if (wb_opcode_i == op_load)
                return wb_rdata_i;
            return (wb_opcode_i == op_lui) ? wb_u_imm_i : wb_alu_i;
        end
        return own;
    endfunction

    // store in MEM right behind a load of its rs2
    function automatic rv32i_word store_data_rule();
        if (mem_opcode_i == op_store && wb_opcode_i == op_load &&
            wb_rd_i != 5'd0 && wb_rd_i == mem_rs2_i)
            return wb_rdata_i;
        return mem_rs2_val_i;
    endfunction

    // EX, then MEM, then WB
    function automatic rv32i_word branch_source_value(input rv32i_reg rs, input rv32i_word own);
        if (writes_reg(ex_load_regfile_i, ex_rd_i, rs))
            return ex_alu_i;
        if (writes_reg(mem_load_regfile_i, mem_rd_i, rs))
            return (mem_opcode_i == op_load) ? mem_rdata_i : mem_alu_i;
        if (writes_reg(wb_load_regfile_i, wb_rd_i, rs))
            return (wb_opcode_i == op_load) ? wb_rdata_i : wb_alu_i;
        return own;
    endfunction

    function automatic logic branch_condition_met(input branch_funct3_t f,
                                                  input rv32i_word a,
                                                  input rv32i_word b);
        case (f)
            beq:     return a == b;
            bne:     return a != b;
            blt:     return $signed(a) < $signed(b);
            bge:     return $signed(a) >= $signed(b);
            bltu:    return a < b;
            bgeu:    return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // ******************************************************************
    // stimulus and checking helpers
    // ******************************************************************
    task automatic compare_word(input string tname, input string what,
                                input rv32i_word exp, input rv32i_word act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", tname, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic fill_values();
        id_rs1_val_i  = $urandom;
        id_rs2_val_i  = $urandom;
        ex_rs1_val_i  = $urandom;
        ex_rs2_val_i  = $urandom;
        ex_alu_i      = $urandom;
        mem_alu_i     = $urandom;
        mem_u_imm_i   = $urandom;
        mem_rdata_i   = $urandom;
        mem_rs2_val_i = $urandom;
        wb_alu_i      = $urandom;
        wb_u_imm_i    = $urandom;
        wb_rdata_i    = $urandom;
    endtask

    // every rd apart from every source, so nothing forwards
    task automatic set_baseline();
        id_rs1_i           = 5'd1;
        id_rs2_i           = 5'd2;
        ex_rs1_i           = 5'd3;
        ex_rs2_i           = 5'd4;
        ex_rd_i            = 5'd20;
        mem_rd_i           = 5'd21;
        mem_rs2_i          = 5'd22;
        wb_rd_i            = 5'd23;
        ex_load_regfile_i  = 1'b1;
        mem_load_regfile_i = 1'b1;
        wb_load_regfile_i  = 1'b1;
        mem_opcode_i       = op_reg;
        wb_opcode_i        = op_reg;
        br_funct3_i        = beq;
        fill_values();
    endtask

    // small register range so hazards, x0 included, are frequent
    task automatic draw_random_stage();
        id_rs1_i           = rv32i_reg'($urandom_range(3, 0));
        id_rs2_i           = rv32i_reg'($urandom_range(3, 0));
        ex_rs1_i           = rv32i_reg'($urandom_range(3, 0));
        ex_rs2_i           = rv32i_reg'($urandom_range(3, 0));
        ex_rd_i            = rv32i_reg'($urandom_range(3, 0));
        mem_rd_i           = rv32i_reg'($urandom_range(3, 0));
        mem_rs2_i          = rv32i_reg'($urandom_range(3, 0));
        wb_rd_i            = rv32i_reg'($urandom_range(3, 0));
        ex_load_regfile_i  = 1'($urandom);
        mem_load_regfile_i = 1'($urandom);
        wb_load_regfile_i  = 1'($urandom);
        mem_opcode_i       = op_tbl[4'($urandom_range(8, 0))];
        wb_opcode_i        = op_tbl[4'($urandom_range(8, 0))];
        br_funct3_i        = cond_tbl[3'($urandom_range(5, 0))];
        fill_values();
    endtask

    // inputs are already driven, 2 ns after an edge
    task automatic apply_and_check(input string tname);
        rv32i_word exp_a;
        rv32i_word exp_b;
        rv32i_word exp_wd;
        logic      exp_br;
        exp_a  = expected_ex_operand(ex_rs1_i, ex_rs1_val_i);
        exp_b  = expected_ex_operand(ex_rs2_i, ex_rs2_val_i);
        exp_wd = store_data_rule();
        exp_br = branch_condition_met(br_funct3_i,
                                      branch_source_value(id_rs1_i, id_rs1_val_i),
                                      branch_source_value(id_rs2_i, id_rs2_val_i));
        // one cycle of latency
        @(posedge clk);
        #1;
        compare_word(tname, "ex_opnd_a_o", exp_a, ex_opnd_a_o);
        compare_word(tname, "ex_opnd_b_o", exp_b, ex_opnd_b_o);
        compare_word(tname, "mem_wdata_o", exp_wd, mem_wdata_o);
        compare_word(tname, "br_taken_o", {31'd0, exp_br}, {31'd0, br_taken_o});
        // back at the drive point for the next set
        #1;
    endtask

    task automatic close_test(input string tname);
        if (test_errs == 0) begin
            tests_passed++;
            $display("[ OK ] %s", tname);
        end else begin
            tests_failed++;
            $display("[BAD ] %s, %0d mismatches", tname, test_errs);
        end
        test_errs = 0;
    endtask

    // ******************************************************************
    // directed tests
    // ******************************************************************
    task automatic reset_and_idle();
        // flops read zero while reset is held
        @(posedge clk);
        #1;
        compare_word("reset", "ex_opnd_a_o", '0, ex_opnd_a_o);
        compare_word("reset", "ex_opnd_b_o", '0, ex_opnd_b_o);
        compare_word("reset", "mem_wdata_o", '0, mem_wdata_o);
        compare_word("reset", "br_taken_o", '0, {31'd0, br_taken_o});
        wait (rst_n_i === 1'b1);
        @(posedge clk);
        #2;
        set_baseline();
        apply_and_check("no_hazard");
        close_test("reset_and_idle");
    endtask

    task automatic ex_priority();
        set_baseline();
        mem_rd_i = ex_rs1_i;
        wb_rd_i  = ex_rs1_i;
        apply_and_check("mem_beats_wb");
        set_baseline();
        mem_rd_i     = ex_rs1_i;
        wb_rd_i      = ex_rs1_i;
        mem_opcode_i = op_lui;
        apply_and_check("lui_in_mem");
        // only WB matches, its opcode picks the bus
        set_baseline();
        wb_rd_i = ex_rs2_i;
        apply_and_check("wb_alu");
        wb_opcode_i = op_lui;
        apply_and_check("wb_lui");
        wb_opcode_i = op_load;
        apply_and_check("wb_load");
        // x0 with write enable set still reads its own value
        set_baseline();
        ex_rs1_i = 5'd0;
        mem_rd_i = 5'd0;
        wb_rd_i  = 5'd0;
        apply_and_check("x0_ignored");
        set_baseline();
        mem_rd_i           = ex_rs1_i;
        mem_load_regfile_i = 1'b0;
        apply_and_check("we_low");
        close_test("ex_priority");
    endtask

    task automatic load_store_forward();
        set_baseline();
        mem_opcode_i       = op_store;
        mem_load_regfile_i = 1'b0;
        wb_opcode_i        = op_load;
        wb_rd_i            = mem_rs2_i;
        apply_and_check("load_then_store");
        wb_opcode_i = op_reg;
        apply_and_check("alu_then_store");
        wb_opcode_i = op_load;
        wb_rd_i     = 5'd0;
        mem_rs2_i   = 5'd0;
        apply_and_check("x0_store");
        close_test("load_store_forward");
    endtask

    // beq against the bus that should win, so taken means right source
    task automatic branch_priority();
        set_baseline();
        ex_rd_i      = id_rs1_i;
        mem_rd_i     = id_rs1_i;
        wb_rd_i      = id_rs1_i;
        id_rs2_val_i = ex_alu_i;
        apply_and_check("ex_first");
        ex_load_regfile_i = 1'b0;
        id_rs2_val_i      = mem_alu_i;
        apply_and_check("mem_alu");
        mem_opcode_i = op_load;
        id_rs2_val_i = mem_rdata_i;
        apply_and_check("mem_load");
        mem_load_regfile_i = 1'b0;
        id_rs2_val_i       = wb_alu_i;
        apply_and_check("wb_alu");
        wb_opcode_i  = op_load;
        id_rs2_val_i = wb_rdata_i;
        apply_and_check("wb_load");
        // rs2 side forwarded, rs1 from the regfile
        set_baseline();
        mem_rd_i     = id_rs2_i;
        id_rs1_val_i = mem_alu_i;
        apply_and_check("rs2_from_mem");
        close_test("branch_priority");
    endtask

    task automatic branch_conditions();
        for (int p = 0; p < 3; p++) begin
            for (int k = 0; k < 6; k++) begin
                set_baseline();
                // lhs from EX, rhs from WB
                ex_rd_i     = id_rs1_i;
                wb_rd_i     = id_rs2_i;
                br_funct3_i = cond_tbl[3'(k)];
                if (p == 0) begin
                    // negative against positive, blt and bltu disagree
                    ex_alu_i = 32'hffff_fff0;
                    wb_alu_i = 32'h0000_0010;
                end else if (p == 1) begin
                    ex_alu_i = 32'h0000_0010;
                    wb_alu_i = 32'hffff_fff0;
                end else begin
                    wb_alu_i = ex_alu_i;
                end
                apply_and_check($sformatf("%s_%0d", br_funct3_i.name(), p));
            end
        end
        close_test("branch_conditions");
    endtask

    // new contents every cycle, each checked one edge later
    task automatic back_to_back_stream();
        for (int n = 0; n < STREAM_LEN; n++) begin
            draw_random_stage();
            apply_and_check($sformatf("stream_%0d", n));
        end
        close_test("back_to_back_stream");
    endtask

    // ******************************************************************
    // main sequence and watchdog
    // ******************************************************************
    initial begin
        void'($urandom(32'h31835909));
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        set_baseline();
        reset_and_idle();
        ex_priority();
        load_store_forward();
        branch_priority();
        branch_conditions();
        back_to_back_stream();
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : forward_tb

`default_nettype wire

// ==== sim.f ====
src/rv32i_pkg.sv
src/ex_forward_unit.sv
src/branch_forward_unit.sv
src/operand_router.sv
src/forward_top.sv
bench/tb_clock_gen.sv
bench/forward_tb.sv

// ==== Makefile ====
# Verilator flow for the forwarding testbench
TOP := forward_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "ALL TESTS PASSED" sim.log || (echo "simulation failed, see sim.log"; exit 1)

obj_dir/V$(TOP): sim.f $(wildcard src/*.sv bench/*.sv)
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log
